//--- hdl/starforce_pkg.sv
// shared constants and types for the starforce host shell
// bridge addresses decode on the full 32-bit word, no partial matches
// stick thresholds assume unsigned axes with the rest position near 0x80
package starforce_pkg;

    ////////////////////////////////////////
    // bridge address map
    ////////////////////////////////////////
    localparam logic [31:0] addr_lives        = 32'h2000_0000;
    localparam logic [31:0] addr_difficulty   = 32'h3000_0000;
    localparam logic [31:0] addr_bonus        = 32'h4000_0000;
    localparam logic [31:0] addr_demo_sounds  = 32'h5000_0000;
    localparam logic [31:0] addr_reset_toggle = 32'h8000_0000;
    localparam logic [31:0] addr_adapter_ena  = 32'hF200_0000;
    localparam logic [31:0] addr_adapter_cfg  = 32'hF700_0000;

    // switch and adapter field widths
    localparam int lives_w     = 2;
    localparam int diff_w      = 3;
    localparam int bonus_w     = 3;
    localparam int cont_type_w = 5;
    localparam int assign_w    = 2;
    // one colour channel from the game core
    localparam int core_chan_w = 4;

    // adapter settings word, type sits at bit 0
    localparam int cfg_assign_lsb = 6;
    localparam int cfg_blank_bit  = 10;

    ////////////////////////////////////////
    // external controller types
    ////////////////////////////////////////
    localparam logic [cont_type_w-1:0] cont_type_none     = 5'h00;
    localparam logic [cont_type_w-1:0] cont_type_analog_a = 5'h12;
    localparam logic [cont_type_w-1:0] cont_type_analog_b = 5'h13;

    // below low is up/left, above high is down/right
    localparam logic [7:0] stick_low  = 8'h40;
    localparam logic [7:0] stick_high = 8'hC0;

    // bit positions in a 16-bit key word
    localparam int key_up    = 0;
    localparam int key_down  = 1;
    localparam int key_left  = 2;
    localparam int key_right = 3;
    localparam int key_fire  = 4;
    localparam int key_coin  = 14;
    localparam int key_start = 15;

    // switch word as the game sees it, field view or byte view
    typedef union packed {
        struct packed {
            logic               demo_sounds;
            logic               unused_hi;
            logic [lives_w-1:0] lives;
            logic [5:0]         unused_mid;
            logic [diff_w-1:0]  difficulty;
            logic [bonus_w-1:0] bonus;
        } sw;
        struct packed {
            logic [7:0] hi_byte;
            logic [7:0] lo_byte;
        } bytes;
    } dip_word_u;

endpackage

//--- hdl/cfg_regs.sv
// bridge register block for game switches and adapter settings
// no back-pressure, a write lands in the cycle bridge_wr is high
// read data is combinational from bridge_addr
`timescale 1ns/100ps

module cfg_regs
    import starforce_pkg::*;
(
    input  logic                   clk_74a,
    input  logic                   reset,
    input  logic [31:0]            bridge_addr,
    input  logic                   bridge_wr,
    input  logic                   bridge_rd,
    input  logic [31:0]            bridge_wr_data,
    output logic [31:0]            bridge_rd_data,
    output dip_word_u              dip_word,
    output logic                   reset_toggle,
    output logic                   adapter_ena,
    output logic [cont_type_w-1:0] cont_type,
    output logic [assign_w-1:0]    cont_assign,
    output logic                   blank_screen
);

    logic [lives_w-1:0] lives_q;
    logic [diff_w-1:0]  diff_q;
    logic [bonus_w-1:0] bonus_q;
    logic               demo_q;
    logic [31:0]        cfg_rd_word;

    ////////////////////////////////////////
    // write decode
    ////////////////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            lives_q      <= '0;
            diff_q       <= '0;
            bonus_q      <= '0;
            demo_q       <= 1'b0;
            reset_toggle <= 1'b0;
            adapter_ena  <= 1'b0;
            cont_type    <= '0;
            cont_assign  <= '0;
            blank_screen <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                addr_lives:        lives_q     <= bridge_wr_data[lives_w-1:0];
                addr_difficulty:   diff_q      <= bridge_wr_data[diff_w-1:0];
                addr_bonus:        bonus_q     <= bridge_wr_data[bonus_w-1:0];
                addr_demo_sounds:  demo_q      <= bridge_wr_data[0];
                addr_adapter_ena:  adapter_ena <= bridge_wr_data[0];
                // any write flips it, data ignored
                addr_reset_toggle: reset_toggle <= ~reset_toggle;
                addr_adapter_cfg: begin
                    cont_type    <= bridge_wr_data[cont_type_w-1:0];
                    cont_assign  <= bridge_wr_data[cfg_assign_lsb +: assign_w];
                    blank_screen <= bridge_wr_data[cfg_blank_bit];
                end
                default: ;
            endcase
        end
    end

    // adapter settings as laid out on the bus
    always_comb begin
        cfg_rd_word = '0;
        cfg_rd_word[cont_type_w-1:0] = cont_type;
        cfg_rd_word[cfg_assign_lsb +: assign_w] = cont_assign;
        cfg_rd_word[cfg_blank_bit] = blank_screen;
    end

    ////////////////////////////////////////
    // read mux
    ////////////////////////////////////////
    always_comb begin
        case (bridge_addr)
            addr_lives:       bridge_rd_data = 32'(lives_q);
            addr_difficulty:  bridge_rd_data = 32'(diff_q);
            addr_bonus:       bridge_rd_data = 32'(bonus_q);
            addr_demo_sounds: bridge_rd_data = 32'(demo_q);
            addr_adapter_ena: bridge_rd_data = 32'(adapter_ena);
            addr_adapter_cfg: bridge_rd_data = cfg_rd_word;
            // toggle reads back as zero, like unmapped space
            default:          bridge_rd_data = '0;
        endcase
    end

    // switch word, unused bits stay zero
    always_comb begin
        dip_word = '0;
        dip_word.sw.demo_sounds = demo_q;
        dip_word.sw.lives       = lives_q;
        dip_word.sw.difficulty  = diff_q;
        dip_word.sw.bonus       = bonus_q;
    end

    // host never reads and writes in the same cycle
    a_no_rd_wr: assert property (@(posedge clk_74a) disable iff (reset)
        !(bridge_rd && bridge_wr));

endmodule

//--- hdl/core_reset.sv
// merged reset for the game core
// soft hold starts two cycles after a toggle write, toggles during it are dropped
// game_reset is registered, one cycle behind its sources
`timescale 1ns/100ps

module core_reset #(
    parameter int reset_hold_cycles = 2**21
) (
    input  logic clk_74a,
    input  logic reset,
    input  logic rom_write_req,
    input  logic rom_all_done,
    input  logic reset_toggle,
    output logic game_reset
);

    localparam int cnt_w = $clog2(reset_hold_cycles + 1);

    logic             rom_window;
    logic             toggle_q;
    logic             toggle_edge;
    logic [cnt_w-1:0] hold_cnt;

    // any change of the toggle level is a request
    assign toggle_edge = reset_toggle ^ toggle_q;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            rom_window <= 1'b0;
            toggle_q   <= 1'b0;
            hold_cnt   <= '0;
            game_reset <= 1'b1;
        end else begin
            // download window, open wins over done
            if (rom_write_req) begin
                rom_window <= 1'b1;
            end else if (rom_all_done) begin
                rom_window <= 1'b0;
            end
            toggle_q <= reset_toggle;
            // hold timer, only reloads once idle
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - cnt_w'(1);
            end else if (toggle_edge) begin
                hold_cnt <= cnt_w'(reset_hold_cycles);
            end
            game_reset <= rom_window || (hold_cnt != '0);
        end
    end

    a_hold_range: assert property (@(posedge clk_74a) disable iff (reset)
        hold_cnt <= cnt_w'(reset_hold_cycles));

endmodule

//--- hdl/control_router.sv
// player one control source select
// adapter off or no controller type means the handheld pad
// analog types replace the dpad bits with left stick thresholds
`timescale 1ns/100ps

module control_router
    import starforce_pkg::*;
(
    input  logic                   clk_74a,
    input  logic                   reset,
    input  logic [15:0]            cont1_key,
    input  logic [15:0]            snac_p1_btn,
    input  logic [15:0]            snac_p2_btn,
    input  logic [31:0]            snac_p1_joy,
    input  logic [31:0]            snac_p2_joy,
    input  logic                   adapter_ena,
    input  logic [cont_type_w-1:0] cont_type,
    input  logic [assign_w-1:0]    cont_assign,
    output logic [15:0]            p1_controls
);

    logic        snac_is_analog;
    logic        snac_off;
    logic [15:0] p1_snac;
    logic [15:0] p2_snac;
    logic [15:0] next_controls;

    // snac buttons, dpad optionally from the left stick
    function automatic logic [15:0] snac_word(
        input logic [15:0] btn,
        input logic [31:0] joy,
        input logic        analog
    );
        logic [15:0] word;
        logic [7:0]  axis_x;
        logic [7:0]  axis_y;
        word   = btn;
        axis_x = joy[7:0];
        axis_y = joy[15:8];
        if (analog) begin
            word[key_up]    = axis_y < stick_low;
            word[key_down]  = axis_y > stick_high;
            word[key_left]  = axis_x < stick_low;
            word[key_right] = axis_x > stick_high;
        end
        return word;
    endfunction

    assign snac_is_analog = (cont_type == cont_type_analog_a) ||
                            (cont_type == cont_type_analog_b);
    assign snac_off = !adapter_ena || (cont_type == cont_type_none);

    assign p1_snac = snac_word(snac_p1_btn, snac_p1_joy, snac_is_analog);
    assign p2_snac = snac_word(snac_p2_btn, snac_p2_joy, snac_is_analog);

    ////////////////////////////////////////
    // player assignment
    ////////////////////////////////////////
    always_comb begin
        if (snac_off) begin
            next_controls = cont1_key;
        end else begin
            case (cont_assign)
                2'd0:    next_controls = p1_snac;
                // snac goes to player two, pocket keeps player one
                2'd1:    next_controls = cont1_key;
                2'd2:    next_controls = p1_snac;
                default: next_controls = p2_snac;
            endcase
        end
    end

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_controls <= '0;
        end else begin
            p1_controls <= next_controls;
        end
    end

endmodule

//--- hdl/coin_pulse.sv
// stretches a coin release into a pulse of pulse_cycles
// releases seen during a pulse do not restart it
`timescale 1ns/100ps

module coin_pulse #(
    parameter int pulse_cycles = 2**20
) (
    input  logic clk_74a,
    input  logic reset,
    input  logic coin_in,
    output logic coin_out
);

    localparam int cnt_w = $clog2(pulse_cycles + 1);

    logic             coin_prev;
    logic [cnt_w-1:0] pulse_cnt;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            coin_prev <= 1'b0;
            pulse_cnt <= '0;
        end else begin
            coin_prev <= coin_in;
            if (pulse_cnt != '0) begin
                pulse_cnt <= pulse_cnt - cnt_w'(1);
            end else if (coin_prev && !coin_in) begin
                // falling edge, button let go
                pulse_cnt <= cnt_w'(pulse_cycles);
            end
        end
    end

    assign coin_out = (pulse_cnt != '0);

    a_no_reload: assert property (@(posedge clk_74a) disable iff (reset)
        (pulse_cnt != '0) |=> (pulse_cnt == $past(pulse_cnt) - cnt_w'(1)));

endmodule

//--- hdl/video_out.sv
// video output stage, everything one cycle behind the core
// 4-bit channels widened by nibble repeat
// syncs leave as one-cycle pulses on the rising edge
`timescale 1ns/100ps

module video_out
    import starforce_pkg::*;
(
    input  logic                     clk_74a,
    input  logic                     reset,
    input  logic [3*core_chan_w-1:0] core_rgb,
    input  logic                     core_hblank,
    input  logic                     core_vblank,
    input  logic                     core_hs,
    input  logic                     core_vs,
    input  logic                     blank_screen,
    input  logic                     adapter_ena,
    output logic [6*core_chan_w-1:0] video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs
);

    logic [core_chan_w-1:0] red;
    logic [core_chan_w-1:0] grn;
    logic [core_chan_w-1:0] blu;
    logic                   active;
    logic                   mute;
    logic                   hs_prev;
    logic                   vs_prev;

    assign {red, grn, blu} = core_rgb;
    assign active = !(core_hblank || core_vblank);
    // screen blank only when the adapter drives the display
    assign mute = !active || (blank_screen && adapter_ena);

    // colour path
    always_ff @(posedge clk_74a) begin
        video_rgb <= mute ? '0 : {red, red, grn, grn, blu, blu};
    end

    ////////////////////////////////////////
    // enable and sync pulses
    ////////////////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
        end else begin
            video_de <= active;
            video_hs <= core_hs && !hs_prev;
            video_vs <= core_vs && !vs_prev;
            hs_prev  <= core_hs;
            vs_prev  <= core_vs;
        end
    end

endmodule

//--- hdl/starforce_top.sv
// host shell top for the starforce core, single clk_74a domain
// game_dipsw is the switch word with its bytes swapped
// game_controls bit 6 is up, bit 0 the stretched coin
`timescale 1ns/100ps

module starforce_top
    import starforce_pkg::*;
#(
    parameter int reset_hold_cycles = 2**21,
    parameter int pulse_cycles      = 2**20
) (
    input  logic        clk_74a,
    input  logic        reset,
    input  logic [31:0] bridge_addr,
    input  logic [31:0] bridge_wr_data,
    input  logic        bridge_wr,
    input  logic        bridge_rd,
    output logic [31:0] bridge_rd_data,
    input  logic        rom_write_req,
    input  logic        rom_all_done,
    input  logic [15:0] cont1_key,
    input  logic [15:0] snac_p1_btn,
    input  logic [15:0] snac_p2_btn,
    input  logic [31:0] snac_p1_joy,
    input  logic [31:0] snac_p2_joy,
    input  logic [11:0] core_rgb,
    input  logic        core_hblank,
    input  logic        core_vblank,
    input  logic        core_hs,
    input  logic        core_vs,
    output logic        game_reset,
    output logic [6:0]  game_controls,
    output logic [15:0] game_dipsw,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs
);

    dip_word_u              dip_word;
    logic                   reset_toggle;
    logic                   adapter_ena;
    logic [cont_type_w-1:0] cont_type;
    logic [assign_w-1:0]    cont_assign;
    logic                   blank_screen;
    logic [15:0]            p1_controls;
    logic                   coin_stretched;

    ////////////////////////////////////////
    // bridge registers and reset
    ////////////////////////////////////////
    cfg_regs u_cfg_regs (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_rd      (bridge_rd),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .dip_word       (dip_word),
        .reset_toggle   (reset_toggle),
        .adapter_ena    (adapter_ena),
        .cont_type      (cont_type),
        .cont_assign    (cont_assign),
        .blank_screen   (blank_screen)
    );

    core_reset #(
        .reset_hold_cycles (reset_hold_cycles)
    ) u_core_reset (
        .clk_74a       (clk_74a),
        .reset         (reset),
        .rom_write_req (rom_write_req),
        .rom_all_done  (rom_all_done),
        .reset_toggle  (reset_toggle),
        .game_reset    (game_reset)
    );

    // game core expects the low byte first
    assign game_dipsw = {dip_word.bytes.lo_byte, dip_word.bytes.hi_byte};

    ////////////////////////////////////////
    // controls
    ////////////////////////////////////////
    control_router u_control_router (
        .clk_74a     (clk_74a),
        .reset       (reset),
        .cont1_key   (cont1_key),
        .snac_p1_btn (snac_p1_btn),
        .snac_p2_btn (snac_p2_btn),
        .snac_p1_joy (snac_p1_joy),
        .snac_p2_joy (snac_p2_joy),
        .adapter_ena (adapter_ena),
        .cont_type   (cont_type),
        .cont_assign (cont_assign),
        .p1_controls (p1_controls)
    );

    coin_pulse #(
        .pulse_cycles (pulse_cycles)
    ) u_coin_pulse (
        .clk_74a  (clk_74a),
        .reset    (reset),
        .coin_in  (p1_controls[key_coin]),
        .coin_out (coin_stretched)
    );

    assign game_controls = {p1_controls[key_up], p1_controls[key_down],
                            p1_controls[key_left], p1_controls[key_right],
                            p1_controls[key_fire], p1_controls[key_start],
                            coin_stretched};

    // video
    video_out u_video_out (
        .clk_74a      (clk_74a),
        .reset        (reset),
        .core_rgb     (core_rgb),
        .core_hblank  (core_hblank),
        .core_vblank  (core_vblank),
        .core_hs      (core_hs),
        .core_vs      (core_vs),
        .blank_screen (blank_screen),
        .adapter_ena  (adapter_ena),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs)
    );

endmodule

//--- verification/starforce_tb.sv
// directed testbench for starforce_top
// durations cut to a 16-cycle soft reset hold and an 8-cycle coin pulse
// inputs change on the falling edge, outputs are sampled there as well
`timescale 1ns/100ps

module starforce_tb
    import starforce_pkg::*;
();

    logic        clk_74a;
    logic        reset;
    logic [31:0] bridge_addr;
    logic [31:0] bridge_wr_data;
    logic        bridge_wr;
    logic        bridge_rd;
    logic [31:0] bridge_rd_data;
    logic        rom_write_req;
    logic        rom_all_done;
    logic [15:0] cont1_key;
    logic [15:0] snac_p1_btn;
    logic [15:0] snac_p2_btn;
    logic [31:0] snac_p1_joy;
    logic [31:0] snac_p2_joy;
    logic [11:0] core_rgb;
    logic        core_hblank;
    logic        core_vblank;
    logic        core_hs;
    logic        core_vs;
    logic        game_reset;
    logic [6:0]  game_controls;
    logic [15:0] game_dipsw;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;

    int          errors;
    int          checks;
    logic        timed_out;
    logic [31:0] lcg_state;

    starforce_top #(
        .reset_hold_cycles (16),
        .pulse_cycles      (8)
    ) u_starforce_top (.*);

    initial begin
        clk_74a = 1'b0;
        forever #10 clk_74a = ~clk_74a;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper lcg bits, coin key held up
    function automatic logic [15:0] random_pad();
        logic [31:0] r;
        r = next_random();
        return r[31:16] & 16'hBFFF;
    endfunction

    // up, down, left, right, fire, start as game_controls[6:1]
    function automatic logic [5:0] pad_controls(input logic [15:0] pad);
        return {pad[0], pad[1], pad[2], pad[3], pad[4], pad[15]};
    endfunction

    // type in 4..0, assignment in 7..6, blank flag in bit 10
    function automatic logic [31:0] adapter_word(input logic [4:0] ctype,
                                                 input logic [1:0] asg,
                                                 input logic       blank);
        return {21'd0, blank, 2'd0, asg, 1'b0, ctype};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("Error: %s expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %s did not happen in time", what);
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_74a);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    // address held a full cycle before the combinational data is taken
    task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk_74a);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge clk_74a);
        data      = bridge_rd_data;
        bridge_rd = 1'b0;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic cfg_regs_readback();
        logic [31:0] rd;
        logic [15:0] fields;
        // upper data bits must be dropped
        bridge_write(addr_lives, 32'hFFFF_FFF6);
        bridge_write(addr_difficulty, 32'd5);
        bridge_write(addr_bonus, 32'd3);
        bridge_write(addr_demo_sounds, 32'd1);
        bridge_read(addr_lives, rd);
        check_value("cfg lives", 32'd2, rd);
        bridge_read(addr_difficulty, rd);
        check_value("cfg difficulty", 32'd5, rd);
        bridge_read(addr_bonus, rd);
        check_value("cfg bonus", 32'd3, rd);
        bridge_read(addr_demo_sounds, rd);
        check_value("cfg demo sounds", 32'd1, rd);
        // demo, spare, lives, six spare, difficulty, bonus
        fields = {1'b1, 1'b0, 2'd2, 6'd0, 3'd5, 3'd3};
        check_value("cfg dipsw", 32'({fields[7:0], fields[15:8]}), 32'(game_dipsw));
        bridge_read(32'h1234_5678, rd);
        check_value("cfg unmapped read", 32'd0, rd);
    endtask

    task automatic controller_routing();
        int          i;
        logic [15:0] pad;
        logic [15:0] p1;
        logic [15:0] p2;
        logic [31:0] r;
        logic [7:0]  ax;
        logic [7:0]  ay;
        logic [5:0]  expected;
        // adapter off, pocket pad only
        for (i = 0; i < 4; i++) begin
            @(negedge clk_74a);
            pad         = random_pad();
            cont1_key   = pad;
            snac_p1_btn = random_pad();
            snac_p2_btn = random_pad();
            @(negedge clk_74a);
            check_value("route pocket", 32'(pad_controls(pad)), 32'(game_controls[6:1]));
        end
        // digital adapter through all four assignments
        bridge_write(addr_adapter_ena, 32'd1);
        for (i = 0; i < 4; i++) begin
            bridge_write(addr_adapter_cfg, adapter_word(5'h01, 2'(i), 1'b0));
            pad         = random_pad();
            p1          = random_pad();
            p2          = random_pad();
            cont1_key   = pad;
            snac_p1_btn = p1;
            snac_p2_btn = p2;
            @(negedge clk_74a);
            case (i)
                1:       expected = pad_controls(pad);
                3:       expected = pad_controls(p2);
                default: expected = pad_controls(p1);
            endcase
            check_value("route assign", 32'(expected), 32'(game_controls[6:1]));
        end
        // analog type, dpad from the left stick
        bridge_write(addr_adapter_cfg, adapter_word(5'h12, 2'd0, 1'b0));
        for (i = 0; i < 8; i++) begin
            p1          = random_pad();
            r           = next_random();
            snac_p1_btn = p1;
            snac_p1_joy = {16'd0, r[31:16]};
            @(negedge clk_74a);
            ay       = r[31:24];
            ax       = r[23:16];
            expected = {ay < 8'h40, ay > 8'hC0, ax < 8'h40, ax > 8'hC0, p1[4], p1[15]};
            check_value("route stick", 32'(expected), 32'(game_controls[6:1]));
        end
        bridge_write(addr_adapter_ena, 32'd0);
        bridge_write(addr_adapter_cfg, 32'd0);
        cont1_key = 16'h0000;
    endtask

    task automatic coin_stretch();
        int t;
        int high;
        int late;
        @(negedge clk_74a);
        cont1_key = 16'h4000;
        repeat (3) @(negedge clk_74a);
        cont1_key = 16'h0000;
        t = 0;
        while (!game_controls[0] && t < 20) begin
            t++;
            @(negedge clk_74a);
        end
        if (!game_controls[0]) begin
            report_timeout("coin pulse start");
            return;
        end
        high = 0;
        while (game_controls[0] && high < 100) begin
            high++;
            @(negedge clk_74a);
        end
        check_value("coin length", 32'd8, 32'(high));
        // second press and release while the pulse runs
        cont1_key = 16'h4000;
        repeat (3) @(negedge clk_74a);
        cont1_key = 16'h0000;
        t = 0;
        while (!game_controls[0] && t < 20) begin
            t++;
            @(negedge clk_74a);
        end
        if (!game_controls[0]) begin
            report_timeout("second coin pulse start");
            return;
        end
        high = 0;
        while (game_controls[0] && high < 100) begin
            high++;
            if (high == 2) cont1_key = 16'h4000;
            if (high == 4) cont1_key = 16'h0000;
            @(negedge clk_74a);
        end
        check_value("coin retrigger length", 32'd8, 32'(high));
        late = 0;
        repeat (12) begin
            @(negedge clk_74a);
            if (game_controls[0]) late++;
        end
        check_value("coin after pulse", 32'd0, 32'(late));
    endtask

    task automatic reset_generator();
        int          t;
        int          high;
        int          drops;
        logic [31:0] rd;
        bridge_write(addr_reset_toggle, 32'd0);
        // toggle level is set now, still reads back as zero
        bridge_read(addr_reset_toggle, rd);
        check_value("cfg toggle read", 32'd0, rd);
        t = 0;
        while (!game_reset && t < 20) begin
            t++;
            @(negedge clk_74a);
        end
        if (!game_reset) begin
            report_timeout("soft reset start");
            return;
        end
        high = 0;
        while (game_reset && high < 100) begin
            high++;
            // another toggle lands inside the hold
            if (high == 4) begin
                bridge_addr = addr_reset_toggle;
                bridge_wr   = 1'b1;
            end
            if (high == 5) bridge_wr = 1'b0;
            @(negedge clk_74a);
        end
        check_value("soft reset hold", 32'd16, 32'(high));
        // rom download window
        rom_write_req = 1'b1;
        @(negedge clk_74a);
        rom_write_req = 1'b0;
        t = 0;
        while (!game_reset && t < 20) begin
            t++;
            @(negedge clk_74a);
        end
        if (!game_reset) begin
            report_timeout("download reset start");
            return;
        end
        drops = 0;
        repeat (6) begin
            @(negedge clk_74a);
            if (!game_reset) drops++;
        end
        check_value("download hold", 32'd0, 32'(drops));
        rom_all_done = 1'b1;
        @(negedge clk_74a);
        check_value("download done +1", 32'd1, 32'(game_reset));
        rom_all_done = 1'b0;
        @(negedge clk_74a);
        check_value("download done +2", 32'd0, 32'(game_reset));
    endtask

    task automatic video_stage();
        int          i;
        int          pulses;
        int          vs_pulses;
        logic [31:0] r;
        logic [11:0] c;
        logic [31:0] rd;
        for (i = 0; i < 10; i++) begin
            r = next_random();
            c = r[31:20];
            @(negedge clk_74a);
            core_rgb    = c;
            // first six active, then hblank, then vblank
            core_hblank = (i >= 6) && (i < 8);
            core_vblank = (i >= 8);
            @(negedge clk_74a);
            if (i < 6) begin
                check_value("video colour",
                    32'({c[11:8], c[11:8], c[7:4], c[7:4], c[3:0], c[3:0]}),
                    32'(video_rgb));
            end else begin
                check_value("video blanked colour", 32'd0, 32'(video_rgb));
            end
            check_value("video de", 32'(i < 6), 32'(video_de));
        end
        core_hblank = 1'b0;
        core_vblank = 1'b0;
        // screen blank through the adapter
        bridge_write(addr_adapter_ena, 32'd1);
        bridge_write(addr_adapter_cfg, adapter_word(5'h00, 2'd0, 1'b1));
        bridge_read(addr_adapter_cfg, rd);
        check_value("video cfg read", adapter_word(5'h00, 2'd0, 1'b1), rd);
        core_rgb = 12'hFFF;
        @(negedge clk_74a);
        check_value("video screen blank", 32'd0, 32'(video_rgb));
        check_value("video screen blank de", 32'd1, 32'(video_de));
        bridge_write(addr_adapter_ena, 32'd0);
        bridge_write(addr_adapter_cfg, 32'd0);
        // four hsync periods of ten cycles
        pulses    = 0;
        vs_pulses = 0;
        for (i = 0; i < 42; i++) begin
            @(negedge clk_74a);
            if (video_hs) pulses++;
            if (video_vs) vs_pulses++;
            core_hs = (i < 40) && ((i % 10) >= 3) && ((i % 10) <= 6);
            // one long vsync across the middle periods
            core_vs = (i >= 12) && (i < 30);
        end
        check_value("video hs pulses", 32'd4, 32'(pulses));
        check_value("video vs pulses", 32'd1, 32'(vs_pulses));
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        errors         = 0;
        checks         = 0;
        timed_out      = 1'b0;
        lcg_state      = 32'h6e1c_fd9c;
        reset          = 1'b1;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        bridge_wr      = 1'b0;
        bridge_rd      = 1'b0;
        rom_write_req  = 1'b0;
        rom_all_done   = 1'b0;
        cont1_key      = '0;
        snac_p1_btn    = '0;
        snac_p2_btn    = '0;
        snac_p1_joy    = '0;
        snac_p2_joy    = '0;
        core_rgb       = '0;
        core_hblank    = 1'b0;
        core_vblank    = 1'b0;
        core_hs        = 1'b0;
        core_vs        = 1'b0;
        repeat (8) @(posedge clk_74a);
        @(negedge clk_74a);
        check_value("reset game_reset", 32'd1, 32'(game_reset));
        reset = 1'b0;
        cfg_regs_readback();
        if (!timed_out) controller_routing();
        if (!timed_out) coin_stretch();
        if (!timed_out) reset_generator();
        if (!timed_out) video_stage();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- starforce.f
hdl/starforce_pkg.sv
hdl/cfg_regs.sv
hdl/core_reset.sv
hdl/control_router.sv
hdl/coin_pulse.sv
hdl/video_out.sv
hdl/starforce_top.sv
verification/starforce_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the starforce testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 \
    --timescale 1ns/100ps \
    --top-module starforce_tb \
    -f starforce.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vstarforce_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF 'All tests passed!'; then
    exit 0
fi
exit 1
